//--- Bender.yml
package:
  name: timer

sources:
  - verilog/timer_pkg.sv
  - verilog/timer_regs.sv
  - verilog/timer_channel.sv
  - verilog/timer_irq.sv
  - verilog/timer_top.sv
  - target: test
    files:
      - verif/tb_timer_top.sv

//--- files.f
verilog/timer_pkg.sv
verilog/timer_regs.sv
verilog/timer_channel.sv
verilog/timer_irq.sv
verilog/timer_top.sv
verif/tb_timer_top.sv

//--- verif/tb_timer_top.sv
/* Interval timer testbench: register access, channel periods, interrupt
   clear and mask, disabled channels and decode errors over AXI4-Lite */
`default_nettype none

module tb_timer_top import timer_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic              clk = 1'b0;
    logic              arst_n;
    axil_addr_t        awaddr;
    logic              awvalid;
    logic              awready;
    axil_data_t        wdata;
    logic [strb_w-1:0] wstrb;
    logic              wvalid;
    logic              wready;
    axil_resp_t        bresp;
    logic              bvalid;
    logic              bready;
    axil_addr_t        araddr;
    logic              arvalid;
    logic              arready;
    axil_data_t        rdata;
    axil_resp_t        rresp;
    logic              rvalid;
    logic              rready;
    logic              irq;

    int cyc = 0;                                             // rising edges since time zero
    int errors = 0;
    int tests_pass = 0;
    int tests_fail = 0;
    int test_err0 = 0;
    int limit = 0;
    int arm_period = 0;                                      // nonzero arms the monitor on the next write
    int exp_rise = 0;
    bit armed = 1'b0;
    bit irq_prev = 1'b0;
    int set_p1 [5];
    int set_p2 [5];
    int set_ar [5];

    timer_top u_dut (.*);

    initial begin
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    function automatic int expected_period(input int p1, input int p2, input int a);
        if (a == 0) return 0;                                // a zero reload stops the channel
        return (p1 + 1) * (p2 + 1) * a;
    endfunction

    function automatic axil_addr_t reg_addr(input int c, input int off);
        return axil_addr_t'(c * 16 + off);
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                              output axil_resp_t resp, output int accept);
        @(posedge clk);
        #1;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!awready) @(negedge clk);
        check("wready with awready", wready, 1'b1);
        accept = cyc + 1;                                    // the coming edge takes the write
        if (arm_period > 0) begin
            exp_rise   = accept + arm_period + 1;
            armed      = 1'b1;
            arm_period = 0;
        end
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        resp = bresp;
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                             output axil_resp_t resp);
        @(posedge clk);
        #1;
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        rready  = 1'b1;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        data = rdata;
        resp = rresp;
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    task automatic write_ok(input axil_addr_t addr, input axil_data_t data);
        axil_resp_t resp;
        int         acc;
        axil_write(addr, data, resp, acc);
        check($sformatf("bresp at %0h", addr), resp, resp_okay);
    endtask

    task automatic read_expect(input axil_addr_t addr, input axil_data_t exp);
        axil_data_t data;
        axil_resp_t resp;
        axil_read(addr, data, resp);
        check($sformatf("rdata at %0h", addr), data, exp);
        check($sformatf("rresp at %0h", addr), resp, resp_okay);
    endtask

    task automatic wait_irq(input int max_cycles);
        int n;
        n = 0;
        while (!irq && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (!irq) begin
            $display("irq did not rise within %0d cycles at %0t", max_cycles, $time);
            errors++;
            armed = 1'b0;
        end
        @(posedge clk);                                      // the monitor has seen the rise by now
    endtask

    task automatic end_test(input string name);
        if (errors == test_err0) begin
            tests_pass++;
            $display("test %s passed", name);
        end else begin
            tests_fail++;
            $display("test %s failed", name);
        end
        test_err0 = errors;
    endtask

    // compares each armed irq rise with the cycle the period predicts
    initial begin
        forever begin
            @(negedge clk);
            if (irq && !irq_prev && armed) begin
                check("irq rise cycle", cyc, exp_rise);
                armed = 1'b0;
            end
            irq_prev = irq;
        end
    end

    initial begin
        wait (limit > 0);
        repeat (limit) @(posedge clk);
        $display("run timed out after %0d cycles", limit);
        $display("Something failed");
        $finish;
    end

    initial begin
        int          max_p;
        int          p;
        bit          dup;
        axil_resp_t  resp;
        axil_data_t  data;
        int          acc;
        logic [7:0]  cfg [n_channels][4];
        logic [3:0]  mask_val;
        arst_n  = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '1;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        void'($urandom(32'h3bab));
        max_p = 0;
        for (int i = 0; i < 5; i++) begin
            do begin
                set_p1[i] = $urandom_range(3, 0);
                set_p2[i] = $urandom_range(3, 0);
                set_ar[i] = $urandom_range(5, 1);
                dup = 1'b0;
                for (int j = 0; j < i; j++) begin
                    if (set_p1[i] == set_p1[j] && set_p2[i] == set_p2[j] &&
                        set_ar[i] == set_ar[j]) dup = 1'b1;
                end
            end while (dup);
            p = expected_period(set_p1[i], set_p2[i], set_ar[i]);
            limit += 4 * p;
            if (p > max_p) max_p = p;
        end
        limit += 2000;
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;

        read_expect(off_pending, 0);
        for (int c = 0; c < n_channels; c++) begin
            for (int r = 0; r < 4; r++) begin
                cfg[c][r] = (r == 3) ? $urandom_range(1, 0) : $urandom_range(255, 0);
                write_ok(reg_addr(c, r * 4), cfg[c][r]);
            end
        end
        mask_val = $urandom_range(15, 0);
        write_ok(off_mask, mask_val);
        for (int c = 0; c < n_channels; c++) begin
            for (int r = 0; r < 4; r++) read_expect(reg_addr(c, r * 4), cfg[c][r]);
        end
        read_expect(off_mask, mask_val);
        for (int c = 0; c < n_channels; c++) write_ok(reg_addr(c, off_ctrl), 0);
        write_ok(off_mask, 0);
        write_ok(off_pending, 4'hF);
        end_test("register access");

        p = expected_period(set_p1[4], set_p2[4], set_ar[4]);
        write_ok(reg_addr(0, off_pre1), set_p1[4]);
        write_ok(reg_addr(0, off_pre2), set_p2[4]);
        write_ok(reg_addr(0, off_arr), set_ar[4]);
        write_ok(off_mask, 1);
        arm_period = p;
        write_ok(reg_addr(0, off_ctrl), 1);
        wait_irq(p + 10);
        end_test("period");

        write_ok(reg_addr(0, off_ctrl), 0);                  // stop it so the clear sticks
        write_ok(off_pending, 1);
        check("irq after clear", irq, 0);
        read_expect(off_pending, 0);
        write_ok(off_mask, 0);
        write_ok(reg_addr(0, off_ctrl), 1);
        repeat (p + 2) begin
            @(negedge clk);
            check("irq while masked", irq, 0);
        end
        read_expect(off_pending, 1);
        write_ok(off_mask, 1);
        check("irq after unmask", irq, 1);
        write_ok(reg_addr(0, off_ctrl), 0);
        write_ok(off_pending, 4'hF);
        end_test("clear and mask");

        // short prescalers, so a channel that wrongly runs ticks inside the window
        write_ok(reg_addr(1, off_pre1), set_p1[1]);
        write_ok(reg_addr(1, off_pre2), set_p2[1]);
        write_ok(reg_addr(1, off_arr), 0);
        write_ok(reg_addr(1, off_ctrl), 1);
        write_ok(reg_addr(2, off_pre1), set_p1[2]);
        write_ok(reg_addr(2, off_pre2), set_p2[2]);
        write_ok(reg_addr(2, off_arr), set_ar[2]);
        write_ok(reg_addr(2, off_ctrl), 0);
        repeat (2 * max_p) @(negedge clk);
        read_expect(off_pending, 0);
        write_ok(reg_addr(1, off_ctrl), 0);
        end_test("disable");

        write_ok(off_mask, 0);
        for (int c = 0; c < n_channels; c++) begin
            write_ok(reg_addr(c, off_pre1), set_p1[c]);
            write_ok(reg_addr(c, off_pre2), set_p2[c]);
            write_ok(reg_addr(c, off_arr), set_ar[c]);
        end
        write_ok(off_pending, 4'hF);
        for (int c = 0; c < n_channels; c++) write_ok(reg_addr(c, off_ctrl), 1);
        repeat (max_p + 10) @(negedge clk);
        read_expect(off_pending, 4'hF);
        for (int c = 0; c < n_channels; c++) write_ok(reg_addr(c, off_ctrl), 0);
        for (int c = 0; c < n_channels; c++) begin
            write_ok(off_pending, 4'hF);
            write_ok(off_mask, 1 << c);
            p = expected_period(set_p1[c], set_p2[c], set_ar[c]);
            arm_period = p;
            write_ok(reg_addr(c, off_ctrl), 1);
            wait_irq(p + 10);
            write_ok(reg_addr(c, off_ctrl), 0);
        end
        write_ok(off_pending, 4'hF);
        end_test("all channels");

        axil_write(8'h48, 32'hFFFF_FFFF, resp, acc);
        check("bresp above mask", resp, resp_slverr);
        axil_write(8'h80, 32'hFFFF_FFFF, resp, acc);
        check("bresp far out", resp, resp_slverr);
        axil_read(8'h48, data, resp);
        check("rdata above mask", data, 0);
        check("rresp above mask", resp, resp_slverr);
        read_expect(reg_addr(0, off_pre1), set_p1[0]);
        read_expect(reg_addr(0, off_arr), set_ar[0]);
        read_expect(off_mask, 4'h8);
        end_test("decode errors");

        $display("tests passed %0d failed %0d", tests_pass, tests_fail);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/timer_channel.sv
/* Timer channel: two prescalers and an auto-reload counter in a chain,
   one tick every (pre1+1)*(pre2+1)*arr cycles */
`default_nettype none

module timer_channel import timer_pkg::*; (
    input  wire          clk,
    input  wire          arst_n,
    input  wire presc_t  pre1,
    input  wire presc_t  pre2,
    input  wire reload_t arr,
    input  wire          en,
    input  wire          load,
    output logic         tick
);

    // nine bits so that every 8-bit setting, 0xFF included, divides correctly
    logic [8:0] cnt1;
    logic [8:0] cnt2;
    logic [8:0] cnt3;
    logic [8:0] term3;
    logic       active;
    logic       wrap1;
    logic       wrap2;
    logic       wrap3;

    assign active = en && (arr != '0);
    assign term3  = {1'b0, arr} - 9'd1;                      // arr counts, so stop one short

    assign wrap1 = (cnt1 == {1'b0, pre1});
    assign wrap2 = wrap1 && (cnt2 == {1'b0, pre2});
    assign wrap3 = wrap2 && (cnt3 == term3);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt1 <= '0;
            cnt2 <= '0;
            cnt3 <= '0;
            tick <= 1'b0;
        end else if (load || !active) begin
            cnt1 <= '0;                                      // restart from a clean phase
            cnt2 <= '0;
            cnt3 <= '0;
            tick <= 1'b0;
        end else begin
            cnt1 <= wrap1 ? 9'd0 : cnt1 + 9'd1;
            if (wrap1) begin
                cnt2 <= wrap2 ? 9'd0 : cnt2 + 9'd1;
            end
            if (wrap2) begin
                cnt3 <= wrap3 ? 9'd0 : cnt3 + 9'd1;
            end
            tick <= wrap3;                                   // one cycle per reload wrap
        end
    end

    a_tick_active: assert property (@(posedge clk) disable iff (!arst_n)
        tick |-> en && (arr != '0))
        else $error("tick raised on a disabled channel");

endmodule

`default_nettype wire

//--- verilog/timer_irq.sv
/* Timer interrupt block: sticky pending bits per channel, write-one-to-clear,
   masked into one interrupt line */
`default_nettype none

module timer_irq import timer_pkg::*; (
    input  wire             clk,
    input  wire             arst_n,
    input  wire chan_mask_t tick,
    input  wire chan_mask_t pend_clear,
    input  wire chan_mask_t irq_mask,
    output chan_mask_t      pending,
    output logic            irq
);

    chan_mask_t pending_nxt;

    // a tick in the same cycle as a clear keeps the bit set
    assign pending_nxt = tick | (pending & ~pend_clear);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= '0;
        end else begin
            pending <= pending_nxt;
        end
    end

    assign irq = |(pending & irq_mask);                      // unmasking raises irq at once

endmodule

`default_nettype wire

//--- verilog/timer_pkg.sv
/* Interval timer package with bus widths, channel count, register map
   and the vector types shared by the timer blocks */
`default_nettype none

package timer_pkg;

    localparam int unsigned n_channels = 4;
    localparam int unsigned addr_w     = 8;
    localparam int unsigned data_w     = 32;
    localparam int unsigned strb_w     = data_w / 8;
    localparam int unsigned chan_idx_w = $clog2(n_channels);
    localparam int unsigned reg_off_w  = 4;                  // each channel spans 16 bytes

    typedef logic [7:0]            presc_t;
    typedef logic [7:0]            reload_t;
    typedef logic [n_channels-1:0] chan_mask_t;
    typedef logic [addr_w-1:0]     axil_addr_t;
    typedef logic [data_w-1:0]     axil_data_t;
    typedef logic [1:0]            axil_resp_t;

    // register offsets inside one channel window
    localparam logic [reg_off_w-1:0] off_pre1 = 4'h0;
    localparam logic [reg_off_w-1:0] off_pre2 = 4'h4;
    localparam logic [reg_off_w-1:0] off_arr  = 4'h8;
    localparam logic [reg_off_w-1:0] off_ctrl = 4'hC;        // bit 0 is the enable

    localparam axil_addr_t chan_span   = axil_addr_t'(n_channels << reg_off_w);
    localparam axil_addr_t off_pending = 8'h40;              // write ones to clear
    localparam axil_addr_t off_mask    = 8'h44;

    localparam axil_resp_t resp_okay   = 2'b00;
    localparam axil_resp_t resp_slverr = 2'b10;

endpackage

`default_nettype wire

//--- verilog/timer_regs.sv
/* Timer register block: AXI4-Lite slave holding the channel configuration,
   the interrupt mask and access to the pending bits */
`default_nettype none

module timer_regs import timer_pkg::*; (
    input  wire               clk,
    input  wire               arst_n,
    input  wire axil_addr_t   awaddr,
    input  wire               awvalid,
    output logic              awready,
    input  wire axil_data_t   wdata,
    input  wire [strb_w-1:0]  wstrb,                         // ignored, every write is a full word
    input  wire               wvalid,
    output logic              wready,
    output axil_resp_t        bresp,
    output logic              bvalid,
    input  wire               bready,
    input  wire axil_addr_t   araddr,
    input  wire               arvalid,
    output logic              arready,
    output axil_data_t        rdata,
    output axil_resp_t        rresp,
    output logic              rvalid,
    input  wire               rready,
    output presc_t            pre1 [n_channels],
    output presc_t            pre2 [n_channels],
    output reload_t           arr [n_channels],
    output chan_mask_t        chan_en,
    output chan_mask_t        cfg_load,
    output chan_mask_t        irq_mask,
    output chan_mask_t        pend_clear,
    input  wire chan_mask_t   pending
);

    typedef enum logic {w_idle, w_resp} wr_state_t;
    typedef enum logic {r_idle, r_resp} rd_state_t;

    wr_state_t wr_state;
    rd_state_t rd_state;

    logic                  wr_fire, rd_fire;
    logic                  wr_chan_hit, rd_chan_hit;
    logic                  wr_addr_ok, rd_addr_ok;
    logic [chan_idx_w-1:0] wr_idx, rd_idx;
    logic [reg_off_w-1:0]  wr_off, rd_off;
    axil_data_t            rd_data_c;

    // address decode for both channels of the bus
    assign wr_chan_hit = awaddr < chan_span;
    assign wr_idx      = awaddr[reg_off_w +: chan_idx_w];
    assign wr_off      = awaddr[reg_off_w-1:0];
    assign wr_addr_ok  = (wr_chan_hit && wr_off[1:0] == 2'b00) ||
                         awaddr == off_pending || awaddr == off_mask;

    assign rd_chan_hit = araddr < chan_span;
    assign rd_idx      = araddr[reg_off_w +: chan_idx_w];
    assign rd_off      = araddr[reg_off_w-1:0];
    assign rd_addr_ok  = (rd_chan_hit && rd_off[1:0] == 2'b00) ||
                         araddr == off_pending || araddr == off_mask;

    // address and data are taken together in one cycle
    assign wr_fire = (wr_state == w_idle) && awvalid && wvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;
    assign bvalid  = (wr_state == w_resp);

    assign rd_fire = (rd_state == r_idle) && arvalid;
    assign arready = rd_fire;
    assign rvalid  = (rd_state == r_resp);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_state <= w_idle;
            bresp    <= resp_okay;
        end else begin
            case (wr_state)
                w_idle: if (wr_fire) begin
                    wr_state <= w_resp;
                    bresp    <= wr_addr_ok ? resp_okay : resp_slverr;
                end
                w_resp: if (bready) wr_state <= w_idle;
                default: wr_state <= w_idle;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int c = 0; c < n_channels; c++) begin
                pre1[c] <= '0;
                pre2[c] <= '0;
                arr[c]  <= '0;
            end
            chan_en  <= '0;
            irq_mask <= '0;
        end else if (wr_fire && wr_chan_hit) begin
            case (wr_off)
                off_pre1: pre1[wr_idx]    <= presc_t'(wdata);
                off_pre2: pre2[wr_idx]    <= presc_t'(wdata);
                off_arr:  arr[wr_idx]     <= reload_t'(wdata);
                off_ctrl: chan_en[wr_idx] <= wdata[0];
                default: ;                                    // unaligned, no effect
            endcase
        end else if (wr_fire && awaddr == off_mask) begin
            irq_mask <= chan_mask_t'(wdata);
        end
    end

    // the channel restarts on the same edge that takes the new value
    always_comb begin
        cfg_load = '0;
        if (wr_fire && wr_chan_hit && wr_addr_ok) begin
            cfg_load[wr_idx] = 1'b1;
        end
    end

    assign pend_clear = (wr_fire && awaddr == off_pending) ? chan_mask_t'(wdata) : '0;

    always_comb begin
        rd_data_c = '0;                                       // unmapped reads return zero
        if (rd_chan_hit) begin
            case (rd_off)
                off_pre1: rd_data_c = axil_data_t'(pre1[rd_idx]);
                off_pre2: rd_data_c = axil_data_t'(pre2[rd_idx]);
                off_arr:  rd_data_c = axil_data_t'(arr[rd_idx]);
                off_ctrl: rd_data_c = axil_data_t'(chan_en[rd_idx]);
                default:  rd_data_c = '0;
            endcase
        end else if (araddr == off_pending) begin
            rd_data_c = axil_data_t'(pending);
        end else if (araddr == off_mask) begin
            rd_data_c = axil_data_t'(irq_mask);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_state <= r_idle;
            rresp    <= resp_okay;
        end else begin
            case (rd_state)
                r_idle: if (rd_fire) begin
                    rd_state <= r_resp;
                    rresp    <= rd_addr_ok ? resp_okay : resp_slverr;
                end
                r_resp: if (rready) rd_state <= r_idle;
                default: rd_state <= r_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) rdata <= rd_data_c;
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("bvalid dropped before bready");

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else $error("rvalid dropped or read data changed before rready");

    a_load_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        (|cfg_load) |-> $onehot(cfg_load) ##1 (cfg_load == '0))
        else $error("cfg_load was not a one-hot single-cycle pulse");

endmodule

`default_nettype wire

//--- verilog/timer_top.sv
/* Interval timer top level: AXI4-Lite register block, one timer per channel
   and the interrupt block */
`default_nettype none

module timer_top import timer_pkg::*; (
    input  wire              clk,
    input  wire              arst_n,
    input  wire axil_addr_t  awaddr,
    input  wire              awvalid,
    output logic             awready,
    input  wire axil_data_t  wdata,
    input  wire [strb_w-1:0] wstrb,
    input  wire              wvalid,
    output logic             wready,
    output axil_resp_t       bresp,
    output logic             bvalid,
    input  wire              bready,
    input  wire axil_addr_t  araddr,
    input  wire              arvalid,
    output logic             arready,
    output axil_data_t       rdata,
    output axil_resp_t       rresp,
    output logic             rvalid,
    input  wire              rready,
    output logic             irq
);

    wire presc_t     pre1 [n_channels];
    wire presc_t     pre2 [n_channels];
    wire reload_t    arr [n_channels];
    wire chan_mask_t chan_en;
    wire chan_mask_t cfg_load;
    wire chan_mask_t irq_mask;
    wire chan_mask_t pend_clear;
    wire chan_mask_t pending;
    wire chan_mask_t tick;

    timer_regs u_regs (
        .clk        (clk),
        .arst_n     (arst_n),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .pre1       (pre1),
        .pre2       (pre2),
        .arr        (arr),
        .chan_en    (chan_en),
        .cfg_load   (cfg_load),
        .irq_mask   (irq_mask),
        .pend_clear (pend_clear),
        .pending    (pending)
    );

    for (genvar c = 0; c < n_channels; c++) begin : g_chan
        timer_channel u_chan (
            .clk    (clk),
            .arst_n (arst_n),
            .pre1   (pre1[c]),
            .pre2   (pre2[c]),
            .arr    (arr[c]),
            .en     (chan_en[c]),
            .load   (cfg_load[c]),
            .tick   (tick[c])
        );
    end

    timer_irq u_irq (
        .clk        (clk),
        .arst_n     (arst_n),
        .tick       (tick),
        .pend_clear (pend_clear),
        .irq_mask   (irq_mask),
        .pending    (pending),
        .irq        (irq)
    );

endmodule

`default_nettype wire
